/* Makefile */
SOURCES := $(shell cat list.f)

obj_dir/Vtb_conv: list.f $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module tb_conv -f list.f

.PHONY: run clean

run: obj_dir/Vtb_conv
	@out="$$(obj_dir/Vtb_conv)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

/* list.f */
rtl/conv_pkg.sv
rtl/line_buffer.sv
rtl/window_ctrl.sv
rtl/weight_bank.sv
rtl/conv_tree.sv
rtl/conv_top.sv
tb/conv_checker.sv
tb/tb_conv.sv

/* rtl/conv_pkg.sv */
package conv_pkg;

	// frame and kernel geometry
	localparam int IMG_SIZE     = 6;
	localparam int KERNEL_SIZE  = 5;
	localparam int TAPS         = KERNEL_SIZE * KERNEL_SIZE;
	localparam int OUT_SIZE     = IMG_SIZE - KERNEL_SIZE + 1;
	localparam int BUFFER_DEPTH = (KERNEL_SIZE - 1) * IMG_SIZE + KERNEL_SIZE;
	localparam int COORD_WIDTH  = $clog2(IMG_SIZE);

	// datapath widths
	localparam int PIXEL_WIDTH   = 16;
	localparam int PRODUCT_WIDTH = 2 * PIXEL_WIDTH;
	// guard bits cover the growth of a sum over all taps
	localparam int SUM_WIDTH     = PRODUCT_WIDTH + $clog2(TAPS);

	// product stage plus one register per adder level
	localparam int TREE_LATENCY  = 1 + $clog2(TAPS);

	typedef logic signed [PIXEL_WIDTH-1:0]   pixel_t;
	typedef logic signed [PIXEL_WIDTH-1:0]   weight_t;
	typedef logic signed [PRODUCT_WIDTH-1:0] product_t;
	typedef logic signed [SUM_WIDTH-1:0]     sum_t;

	// tap 0 is the top-left of the window
	typedef logic [TAPS*PIXEL_WIDTH-1:0] window_t;
	typedef logic [TAPS*PIXEL_WIDTH-1:0] kernel_t;

	typedef logic [COORD_WIDTH-1:0] coord_t;

endpackage

/* rtl/conv_top.sv */
`timescale 1ns/100ps

module conv_top
(
	input  logic              clk,
	input  logic              reset,
	input  logic              weight_load,
	input  conv_pkg::weight_t weight_in,
	input  logic              frame_start,
	input  logic              pixel_valid,
	input  conv_pkg::pixel_t  pixel_in,
	output conv_pkg::sum_t    conv_out,
	output logic              conv_valid
);
	import conv_pkg::*;

	window_t window;
	kernel_t kernel;
	logic    conv_enable;

	line_buffer line_buffer_i
	(
		.clk         (clk),
		.reset       (reset),
		.pixel_valid (pixel_valid),
		.pixel_in    (pixel_in),
		.window      (window)
	);

	// marks the cycle a full window sits in the buffer
	window_ctrl window_ctrl_i
	(
		.clk         (clk),
		.reset       (reset),
		.pixel_valid (pixel_valid),
		.frame_start (frame_start),
		.conv_enable (conv_enable)
	);

	weight_bank weight_bank_i
	(
		.clk         (clk),
		.reset       (reset),
		.weight_load (weight_load),
		.weight_in   (weight_in),
		.kernel      (kernel)
	);

	conv_tree conv_tree_i
	(
		.clk         (clk),
		.reset       (reset),
		.conv_enable (conv_enable),
		.window      (window),
		.kernel      (kernel),
		.conv_out    (conv_out),
		.conv_valid  (conv_valid)
	);

endmodule

/* rtl/conv_tree.sv */
`timescale 1ns/100ps

module conv_tree
(
	input  logic              clk,
	input  logic              reset,
	input  logic              conv_enable,
	input  conv_pkg::window_t window,
	input  conv_pkg::kernel_t kernel,
	output conv_pkg::sum_t    conv_out,
	output logic              conv_valid
);
	import conv_pkg::*;

	product_t mul_out [TAPS];
	product_t prod_q  [TAPS];

	// adder levels, the last entry of an odd level passes through
	sum_t lvl1_q [13];
	sum_t lvl2_q [7];
	sum_t lvl3_q [4];
	sum_t lvl4_q [2];
	sum_t lvl5_q;

	logic [TREE_LATENCY-1:0] valid_sr;

	genvar k;
	generate
		for (k = 0; k < TAPS; k++)
		begin : g_mul
			assign mul_out[k] = pixel_t'(window[k * PIXEL_WIDTH +: PIXEL_WIDTH])
				* weight_t'(kernel[k * $bits(weight_t) +: $bits(weight_t)]);
		end
	endgenerate

	// products only capture a completed window
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < TAPS; i++)
				prod_q[i] <= '0;
		end
		else if (conv_enable)
		begin
			for (int i = 0; i < TAPS; i++)
				prod_q[i] <= mul_out[i];
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 13; i++)
				lvl1_q[i] <= '0;
			for (int i = 0; i < 7; i++)
				lvl2_q[i] <= '0;
			for (int i = 0; i < 4; i++)
				lvl3_q[i] <= '0;
			for (int i = 0; i < 2; i++)
				lvl4_q[i] <= '0;
			lvl5_q <= '0;
		end
		else
		begin
			// widen before adding so no carry is lost
			for (int i = 0; i < 12; i++)
				lvl1_q[i] <= sum_t'(prod_q[2 * i]) + sum_t'(prod_q[2 * i + 1]);
			lvl1_q[12] <= sum_t'(prod_q[TAPS - 1]);

			for (int i = 0; i < 6; i++)
				lvl2_q[i] <= lvl1_q[2 * i] + lvl1_q[2 * i + 1];
			lvl2_q[6] <= lvl1_q[12];

			for (int i = 0; i < 3; i++)
				lvl3_q[i] <= lvl2_q[2 * i] + lvl2_q[2 * i + 1];
			lvl3_q[3] <= lvl2_q[6];

			for (int i = 0; i < 2; i++)
				lvl4_q[i] <= lvl3_q[2 * i] + lvl3_q[2 * i + 1];

			lvl5_q <= lvl4_q[0] + lvl4_q[1];
		end
	end

	// enable follows the data through every stage
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			valid_sr <= '0;
		else
			valid_sr <= {valid_sr[TREE_LATENCY-2:0], conv_enable};
	end

	assign conv_out = lvl5_q;
	assign conv_valid = valid_sr[TREE_LATENCY-1];

endmodule

/* rtl/line_buffer.sv */
`timescale 1ns/100ps

module line_buffer
(
	input  logic              clk,
	input  logic              reset,
	input  logic              pixel_valid,
	input  conv_pkg::pixel_t  pixel_in,
	output conv_pkg::window_t window
);
	import conv_pkg::*;

	// index 0 holds the newest pixel
	pixel_t pix_sr [BUFFER_DEPTH];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < BUFFER_DEPTH; i++)
				pix_sr[i] <= '0;
		end
		else if (pixel_valid)
		begin
			pix_sr[0] <= pixel_in;
			for (int i = 1; i < BUFFER_DEPTH; i++)
				pix_sr[i] <= pix_sr[i - 1];
		end
	end

	// window rows sit one image line apart in the chain
	genvar r;
	genvar c;
	generate
		for (r = 0; r < KERNEL_SIZE; r++)
		begin : g_row
			for (c = 0; c < KERNEL_SIZE; c++)
			begin : g_col
				// bottom-right tap is the pixel just shifted in
				assign window[(r * KERNEL_SIZE + c) * PIXEL_WIDTH +: PIXEL_WIDTH] =
					pix_sr[(KERNEL_SIZE - 1 - r) * IMG_SIZE + (KERNEL_SIZE - 1 - c)];
			end
		end
	endgenerate

endmodule

/* rtl/weight_bank.sv */
`timescale 1ns/100ps

module weight_bank
(
	input  logic              clk,
	input  logic              reset,
	input  logic              weight_load,
	input  conv_pkg::weight_t weight_in,
	output conv_pkg::kernel_t kernel
);
	import conv_pkg::*;

	weight_t weights [TAPS];

	// new weights enter at the bottom-right and move toward tap 0
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < TAPS; i++)
				weights[i] <= '0;
		end
		else if (weight_load)
		begin
			weights[TAPS - 1] <= weight_in;
			for (int i = 0; i < TAPS - 1; i++)
				weights[i] <= weights[i + 1];
		end
	end

	genvar k;
	generate
		for (k = 0; k < TAPS; k++)
		begin : g_tap
			assign kernel[k * $bits(weight_t) +: $bits(weight_t)] = weights[k];
		end
	endgenerate

endmodule

/* rtl/window_ctrl.sv */
`timescale 1ns/100ps

module window_ctrl
(
	input  logic clk,
	input  logic reset,
	input  logic pixel_valid,
	input  logic frame_start,
	output logic conv_enable
);
	import conv_pkg::*;

	typedef enum logic
	{
		st_idle,
		st_stream
	} state_t;

	state_t state;
	state_t state_next;
	coord_t row;
	coord_t col;
	coord_t cur_row;
	coord_t cur_col;
	logic   accept;
	logic   last_pixel;
	logic   window_done;

	// position of the pixel on the bus this cycle
	always_comb
	begin
		accept = pixel_valid && (frame_start || state == st_stream);
		// frame_start always restarts at the top-left
		cur_row = frame_start ? '0 : row;
		cur_col = frame_start ? '0 : col;
		last_pixel = (cur_row == coord_t'(IMG_SIZE - 1))
			&& (cur_col == coord_t'(IMG_SIZE - 1));
		// first row and column where a full window fits
		window_done = accept
			&& (cur_row >= coord_t'(IMG_SIZE - OUT_SIZE))
			&& (cur_col >= coord_t'(IMG_SIZE - OUT_SIZE));
	end

	always_comb
	begin
		state_next = state;
		if (accept)
			state_next = last_pixel ? st_idle : st_stream;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= st_idle;
			row <= '0;
			col <= '0;
			conv_enable <= 1'b0;
		end
		else
		begin
			state <= state_next;
			// lines up with the line_buffer shift of the same pixel
			conv_enable <= window_done;
			if (accept)
			begin
				if (cur_col == coord_t'(IMG_SIZE - 1))
				begin
					col <= '0;
					row <= last_pixel ? '0 : cur_row + 1'b1;
				end
				else
				begin
					col <= cur_col + 1'b1;
					row <= cur_row;
				end
			end
		end
	end

endmodule

/* tb/conv_checker.sv */
`timescale 1ns/100ps

module conv_checker
(
	input logic           clk,
	input logic           reset,
	input logic           expect_idle,
	input logic           conv_valid,
	input conv_pkg::sum_t conv_out
);
	import conv_pkg::*;

	sum_t   exp_q [$];
	longint accept_q [$];
	longint cycle_count = 0;
	int     test_results = 0;
	int     test_errors = 0;
	int     total_results = 0;
	int     total_tests = 0;
	int     error_count = 0;

	task automatic expect_result(input sum_t value, input longint accept_cycle);
		exp_q.push_back(value);
		accept_q.push_back(accept_cycle);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	task automatic report_value(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		test_errors++;
	endtask

	// edge count as seen before the update at each posedge
	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	always @(posedge clk)
	begin
		sum_t   expected;
		longint accept_cycle;
		if (!reset && expect_idle && (conv_valid !== 1'b0 || conv_out !== '0))
			report_value($sformatf("output active before any frame, valid %0b out %0d",
				conv_valid, conv_out));
		if (!reset && conv_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("unexpected result %0d at %0t with no window outstanding",
					conv_out, $time);
				test_errors++;
			end
			else
			begin
				expected = exp_q.pop_front();
				accept_cycle = accept_q.pop_front();
				test_results++;
				if (conv_out !== expected)
					report_value($sformatf("conv_out %0d, expected %0d", conv_out, expected));
				// seven edges from accepting the last window pixel to seeing conv_valid
				if (cycle_count - accept_cycle != 7)
					report_value($sformatf("result after %0d cycles, expected 7",
						cycle_count - accept_cycle));
			end
		end
	end

	task automatic finish_test(input int test_id);
		if (exp_q.size() != 0)
		begin
			$display("test %0d: %0d results never arrived", test_id, exp_q.size());
			test_errors += exp_q.size();
			exp_q.delete();
			accept_q.delete();
		end
		$display("test %0d: %0d results checked, %0d errors", test_id, test_results, test_errors);
		total_tests++;
		total_results += test_results;
		error_count += test_errors;
		test_results = 0;
		test_errors = 0;
	endtask

	task automatic report_totals();
		error_count += test_errors;
		test_errors = 0;
		$display("tests %0d, results %0d, errors %0d", total_tests, total_results, error_count);
	endtask

endmodule

/* tb/conv_testdata.txt */
# per test: header with test id and gap flag, 5 weight rows, 6 pixel rows,
# then the 4 expected sums in raster order
1 0
1 1 1 1 1
2 2 2 2 2
3 3 3 3 3
4 4 4 4 4
5 5 5 5 5
1 2 3 4 5 6
7 8 9 10 11 12
13 14 15 16 17 18
19 20 21 22 23 24
25 26 27 28 29 30
31 32 33 34 35 36
1425 1500 1875 1950
2 0
-1 -1 -1 -1 -1
-2 -2 -2 -2 -2
-3 -3 -3 -3 -3
-4 -4 -4 -4 -4
-5 -5 -5 -5 -5
-19 -18 -17 -16 -15 -14
-13 -12 -11 -10 -9 -8
-7 -6 -5 -4 -3 -2
-1 0 1 2 3 4
5 6 7 8 9 10
11 12 13 14 15 16
75 0 -375 -450
3 0
32767 32767 32767 32767 32767
32767 32767 32767 32767 32767
32767 32767 32767 32767 32767
32767 32767 32767 32767 32767
32767 32767 32767 32767 32767
-32768 -32768 -32768 -32768 -32768 -32768
-32768 -32768 -32768 -32768 -32768 -32768
-32768 -32768 -32768 -32768 -32768 -32768
-32768 -32768 -32768 -32768 -32768 -32768
-32768 -32768 -32768 -32768 -32768 -32768
-32768 -32768 -32768 -32768 -32768 -32768
-26842726400 -26842726400 -26842726400 -26842726400
4 1
-1 -1 -1 -1 -1
-2 -2 -2 -2 -2
-3 -3 -3 -3 -3
-4 -4 -4 -4 -4
-5 -5 -5 -5 -5
-19 -18 -17 -16 -15 -14
-13 -12 -11 -10 -9 -8
-7 -6 -5 -4 -3 -2
-1 0 1 2 3 4
5 6 7 8 9 10
11 12 13 14 15 16
75 0 -375 -450

/* tb/tb_conv.sv */
`timescale 1ns/100ps

module tb_conv;
	import conv_pkg::*;

	logic    clk;
	logic    reset;
	logic    weight_load;
	weight_t weight_in;
	logic    frame_start;
	logic    pixel_valid;
	pixel_t  pixel_in;
	sum_t    conv_out;
	logic    conv_valid;
	logic    expect_idle;

	int      seed;
	int      fd;
	int      test_id;
	int      gap_flag;
	bit      data_error;
	weight_t kernel_words [TAPS];
	pixel_t  frame_pixels [IMG_SIZE * IMG_SIZE];
	sum_t    expected_sums [OUT_SIZE * OUT_SIZE];

	conv_top dut_i
	(
		.clk         (clk),
		.reset       (reset),
		.weight_load (weight_load),
		.weight_in   (weight_in),
		.frame_start (frame_start),
		.pixel_valid (pixel_valid),
		.pixel_in    (pixel_in),
		.conv_out    (conv_out),
		.conv_valid  (conv_valid)
	);

	conv_checker checker_i
	(
		.clk         (clk),
		.reset       (reset),
		.expect_idle (expect_idle),
		.conv_valid  (conv_valid),
		.conv_out    (conv_out)
	);

	initial
		clk = 1'b0;

	always #4 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		checker_i.report_totals();
		$display("Result: FAILED");
		$finish;
	endtask

	// skips blank lines and comment lines
	function automatic string next_line();
		string line;
		int    n;
		line = "";
		while (!$feof(fd))
		begin
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line[0] != "#")
				return line;
		end
		return "";
	endfunction

	task automatic read_test(output bit ok);
		string  line;
		int     fields;
		int     v0, v1, v2, v3, v4, v5;
		longint s0, s1, s2, s3;
		line = next_line();
		ok = (line != "");
		if (ok)
		begin
			fields = $sscanf(line, "%d %d", test_id, gap_flag);
			for (int r = 0; r < KERNEL_SIZE; r++)
			begin
				fields += $sscanf(next_line(), "%d %d %d %d %d", v0, v1, v2, v3, v4);
				kernel_words[r * KERNEL_SIZE + 0] = weight_t'(v0);
				kernel_words[r * KERNEL_SIZE + 1] = weight_t'(v1);
				kernel_words[r * KERNEL_SIZE + 2] = weight_t'(v2);
				kernel_words[r * KERNEL_SIZE + 3] = weight_t'(v3);
				kernel_words[r * KERNEL_SIZE + 4] = weight_t'(v4);
			end
			for (int r = 0; r < IMG_SIZE; r++)
			begin
				fields += $sscanf(next_line(), "%d %d %d %d %d %d", v0, v1, v2, v3, v4, v5);
				frame_pixels[r * IMG_SIZE + 0] = pixel_t'(v0);
				frame_pixels[r * IMG_SIZE + 1] = pixel_t'(v1);
				frame_pixels[r * IMG_SIZE + 2] = pixel_t'(v2);
				frame_pixels[r * IMG_SIZE + 3] = pixel_t'(v3);
				frame_pixels[r * IMG_SIZE + 4] = pixel_t'(v4);
				frame_pixels[r * IMG_SIZE + 5] = pixel_t'(v5);
			end
			fields += $sscanf(next_line(), "%d %d %d %d", s0, s1, s2, s3);
			expected_sums[0] = sum_t'(s0);
			expected_sums[1] = sum_t'(s1);
			expected_sums[2] = sum_t'(s2);
			expected_sums[3] = sum_t'(s3);
			if (fields != 67)
			begin
				$display("test data for test %0d is malformed", test_id);
				data_error = 1'b1;
				ok = 1'b0;
			end
		end
	endtask

	// first word ends up at the top-left tap
	task automatic load_weights();
		for (int i = 0; i < TAPS; i++)
		begin
			@(posedge clk);
			weight_load <= 1'b1;
			weight_in <= kernel_words[i];
		end
		@(posedge clk);
		weight_load <= 1'b0;
	endtask

	task automatic stream_frame(input bit gaps);
		int row;
		int col;
		for (int i = 0; i < IMG_SIZE * IMG_SIZE; i++)
		begin
			row = i / IMG_SIZE;
			col = i % IMG_SIZE;
			if (gaps)
			begin
				repeat ($random(seed) & 3)
				begin
					@(posedge clk);
					pixel_valid <= 1'b0;
					frame_start <= 1'b0;
				end
			end
			@(posedge clk);
			pixel_valid <= 1'b1;
			pixel_in <= frame_pixels[i];
			frame_start <= (i == 0);
			// a window is complete once its bottom-right pixel is in
			if (row >= KERNEL_SIZE - 1 && col >= KERNEL_SIZE - 1)
				checker_i.expect_result(
					expected_sums[(row - KERNEL_SIZE + 1) * OUT_SIZE + col - KERNEL_SIZE + 1],
					checker_i.cycle_count + 1);
		end
	endtask

	task automatic go_idle();
		@(posedge clk);
		pixel_valid <= 1'b0;
		frame_start <= 1'b0;
	endtask

	task automatic drain_results(input int id, output bit timed_out);
		int waited;
		waited = 0;
		timed_out = 1'b0;
		while (checker_i.pending() != 0 && waited < 100)
		begin
			@(negedge clk);
			waited++;
		end
		if (checker_i.pending() != 0)
		begin
			$display("timed out waiting for results of test %0d", id);
			timed_out = 1'b1;
		end
		else
		begin
			// quiet window catches stray pulses
			repeat (10) @(negedge clk);
		end
		checker_i.finish_test(id);
	endtask

	task automatic run_tests();
		bit ok;
		bit timed_out;
		timed_out = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		repeat (12) @(posedge clk);
		expect_idle <= 1'b0;
		drain_results(0, timed_out);
		read_test(ok);
		while (ok && !timed_out)
		begin
			load_weights();
			stream_frame(gap_flag != 0);
			go_idle();
			drain_results(test_id, timed_out);
			if (!timed_out)
				read_test(ok);
		end
		$fclose(fd);
		if (!timed_out && !data_error)
		begin
			// last frame three times with no idle cycle in between
			repeat (3) stream_frame(1'b0);
			go_idle();
			drain_results(test_id + 1, timed_out);
		end
		checker_i.report_totals();
		if (checker_i.error_count == 0 && !timed_out && !data_error)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	initial
	begin
		seed = 32'h2849e052;
		reset = 1'b1;
		weight_load = 1'b0;
		weight_in = '0;
		frame_start = 1'b0;
		pixel_valid = 1'b0;
		pixel_in = '0;
		expect_idle = 1'b1;
		data_error = 1'b0;
		fd = $fopen("tb/conv_testdata.txt", "r");
		if (fd == 0)
			abort_run("could not open tb/conv_testdata.txt");
		else
			run_tests();
	end

endmodule
